// File: icache.f
src/icache_pkg.sv
src/icache_ctrl.sv
src/sweep_counter.sv
src/line_ram.sv
src/tag_way.sv
src/nru_state.sv
src/icache_array.sv
test/icache_props.sv
test/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= icache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# the run passes only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/icache_tb.sv
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

  localparam int NUM_SETS  = 32;
  localparam int NUM_WAYS  = 4;
  localparam int IDX_W     = $clog2(NUM_SETS);
  localparam int NUM_TESTS = 6;
  localparam int MAX_OPS   = 200;
  localparam int SWEEPS    = 2;
  localparam int TIMEOUT_CYCLES = 8 + NUM_TESTS * MAX_OPS + SWEEPS * (NUM_SETS + 4);

  logic      clk;
  logic      rst;
  rd_req_t   rd_req;
  fill_req_t fill_req;
  logic      inval_all;
  rd_resp_t  rd_resp;
  evict_t    evict;
  logic      busy;

  // reference model state
  line_addr_t          m_tag [NUM_SETS][NUM_WAYS];
  line_t               m_data [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] m_valid [NUM_SETS];
  logic [NUM_WAYS-1:0] m_nru [NUM_SETS];
  logic                touch_pend;
  int                  touch_set;
  int                  touch_way;
  rd_resp_t            exp_resp;
  evict_t              exp_evict;

  logic [31:0] lfsr;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          errors_at_start;
  int          cycles = 0;
  string       cur_test;

  icache_array #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) icache_array_i (
    .clk       (clk),
    .rst       (rst),
    .rd_req    (rd_req),
    .fill_req  (fill_req),
    .inval_all (inval_all),
    .rd_resp   (rd_resp),
    .evict     (evict),
    .busy      (busy)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run exceeded %0d cycles and was stopped", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  function automatic line_addr_t make_addr(input int tag, input int set);
    return (line_addr_t'(tag) << IDX_W) | line_addr_t'(set);
  endfunction

  function automatic logic [NUM_WAYS-1:0] nru_touch(input logic [NUM_WAYS-1:0] bits,
                                                    input int way);
    logic [NUM_WAYS-1:0] r;
    r = bits;
    r[way] = 1'b1;
    if (r == '1) begin
      r = '0;
      r[way] = 1'b1;
    end
    return r;
  endfunction

  task automatic model_clear();
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_nru[s]   = '0;
    end
    touch_pend = 1'b0;
    exp_resp   = '0;
    exp_evict  = '0;
  endtask

  // one accepting edge where the read sees the state before the fill of the same edge
  task automatic model_accept(input logic rd_en, input line_addr_t rd_addr,
                              input logic fill_en, input line_addr_t fill_addr,
                              input line_t f_line);
    int       rs;
    int       fs;
    int       fw;
    logic     found;
    rd_resp_t r;
    r  = '0;
    rs = int'(rd_addr[IDX_W-1:0]);
    fs = int'(fill_addr[IDX_W-1:0]);
    fw = 0;
    if (rd_en) begin
      r.valid = 1'b1;
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (m_valid[rs][w] && m_tag[rs][w] == rd_addr) begin
          r.hit  = 1'b1;
          r.way  = way_idx_t'(w);
          r.line = m_data[rs][w];
        end
      end
    end
    exp_evict.valid = 1'b0;
    if (fill_en) begin
      found = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (!found && m_valid[fs][w] && m_tag[fs][w] == fill_addr) begin
          fw    = w;
          found = 1'b1;
        end
      end
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (!found && !m_valid[fs][w]) begin
          fw    = w;
          found = 1'b1;
        end
      end
      // victim pick sees the used bits before the pending read touch
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (!found && !m_nru[fs][w]) begin
          fw    = w;
          found = 1'b1;
        end
      end
      exp_evict.valid     = m_valid[fs][fw] && (m_tag[fs][fw] != fill_addr);
      exp_evict.line_addr = m_tag[fs][fw];
    end
    if (touch_pend) begin
      m_nru[touch_set] = nru_touch(m_nru[touch_set], touch_way);
    end
    if (fill_en) begin
      m_nru[fs]      = nru_touch(m_nru[fs], fw);
      m_tag[fs][fw]  = fill_addr;
      m_data[fs][fw] = f_line;
      m_valid[fs][fw] = 1'b1;
    end
    touch_pend = r.hit;
    touch_set  = rs;
    touch_way  = int'(r.way);
    exp_resp   = r;
  endtask

  task automatic check_resp(input rd_resp_t exp, input rd_resp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: rd_resp expected %h actual %h", cur_test, exp, act);
    end
  endtask

  task automatic check_evict(input evict_t exp, input evict_t act);
    logic bad;
    checks++;
    bad = exp.valid ? (act !== exp) : (act.valid !== 1'b0);
    if (bad) begin
      errors++;
      $display("[ERROR] %s: evict expected %h actual %h", cur_test, exp, act);
    end
  endtask

  task automatic check_busy(input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: busy expected %b actual %b", cur_test, exp, act);
    end
  endtask

  // drive one request, then check the results of the one before
  task automatic cycle_op(input logic rd_en, input line_addr_t rd_addr, input logic fill_en,
                          input line_addr_t fill_addr, input line_t f_line);
    @(posedge clk);
    rd_req   <= '{en: rd_en, addr: rd_addr};
    fill_req <= '{en: fill_en, addr: fill_addr, line: f_line};
    @(negedge clk);
    check_resp(exp_resp, rd_resp);
    check_evict(exp_evict, evict);
    check_busy(1'b0, busy);
    model_accept(rd_en, rd_addr, fill_en, fill_addr, f_line);
  endtask

  task automatic read_at(input line_addr_t a);
    cycle_op(1'b1, a, 1'b0, '0, '0);
  endtask

  task automatic fill_at(input line_addr_t a, input line_t d);
    cycle_op(1'b0, '0, 1'b1, a, d);
  endtask

  task automatic idle_cycle();
    cycle_op(1'b0, '0, 1'b0, '0, '0);
  endtask

  // requests offered during the sweep must be dropped without any response
  task automatic expect_sweep();
    for (int i = 0; i < NUM_SETS; i++) begin
      rd_req   <= '{en: 1'b1, addr: make_addr(i, i)};
      fill_req <= '{en: 1'b1, addr: make_addr(i, i), line: '1};
      @(negedge clk);
      check_busy(1'b1, busy);
      check_resp('0, rd_resp);
      check_evict('0, evict);
      @(posedge clk);
    end
    rd_req   <= '0;
    fill_req <= '0;
    @(negedge clk);
    check_busy(1'b0, busy);
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == errors_at_start) begin
      $display("%-16s ok", cur_test);
    end else begin
      $display("%-16s %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  task automatic test_reset_sweep();
    begin_test("reset_sweep");
    expect_sweep();
    for (int i = 0; i < 8; i++) begin
      read_at(line_addr_t'(rand_bits(LINE_ADDR_W)));
    end
    idle_cycle();
    end_test();
  endtask

  task automatic test_fill_then_hit();
    begin_test("fill_then_hit");
    fill_at(make_addr(5, 3), line_t'(rand_bits(LINE_BITS)));
    read_at(make_addr(5, 3));
    read_at(make_addr(6, 3));
    idle_cycle();
    end_test();
  endtask

  task automatic test_nru_eviction();
    begin_test("nru_eviction");
    for (int t = 1; t <= 4; t++) begin
      fill_at(make_addr(t, 7), line_t'(rand_bits(LINE_BITS)));
    end
    read_at(make_addr(1, 7));
    read_at(make_addr(3, 7));
    idle_cycle();
    fill_at(make_addr(9, 7), line_t'(rand_bits(LINE_BITS)));
    read_at(make_addr(9, 7));
    read_at(make_addr(2, 7));
    idle_cycle();
    end_test();
  endtask

  task automatic test_refill_same_tag();
    begin_test("refill_same_tag");
    fill_at(make_addr(3, 7), line_t'(rand_bits(LINE_BITS)));
    read_at(make_addr(3, 7));
    idle_cycle();
    end_test();
  endtask

  task automatic test_invalidate_all();
    begin_test("invalidate_all");
    @(posedge clk);
    inval_all <= 1'b1;
    @(posedge clk);
    inval_all <= 1'b0;
    expect_sweep();
    model_clear();
    read_at(make_addr(5, 3));
    for (int t = 1; t <= 4; t++) begin
      read_at(make_addr(t, 7));
    end
    read_at(make_addr(9, 7));
    idle_cycle();
    end_test();
  endtask

  // small tag and set space so hits, refills and evictions all show up
  task automatic test_random_mix();
    logic [127:0] v;
    begin_test("random_mix");
    for (int i = 0; i < 150; i++) begin
      v = rand_bits(12);
      cycle_op(v[0], make_addr(int'(v[4:2]), int'(v[6:5])),
               v[1], make_addr(int'(v[9:7]), int'(v[11:10])),
               line_t'(rand_bits(LINE_BITS)));
    end
    idle_cycle();
    end_test();
  endtask

  initial begin
    rst       <= 1'b1;
    inval_all <= 1'b0;
    rd_req    <= '0;
    fill_req  <= '0;
    lfsr = 32'h8acc;
    model_clear();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_reset_sweep();
    test_fill_then_hit();
    test_nru_eviction();
    test_refill_same_tag();
    test_invalidate_all();
    test_random_mix();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: test/icache_props.sv
`timescale 1ns/10ps

module icache_props import icache_pkg::*; (
  input logic      clk,
  input logic      rst,
  input rd_req_t   rd_req,
  input fill_req_t fill_req,
  input logic      busy,
  input rd_resp_t  rd_resp,
  input evict_t    evict
);

  // response exactly one cycle after an accepted read
  a_rd_resp_timing: assert property (
    @(posedge clk) disable iff (rst)
    rd_resp.valid == $past(rd_req.en && !busy)
  ) else $error("rd_resp.valid does not follow an accepted read by one cycle");

  // nothing comes out once the sweep has held requests off for a cycle
  a_quiet_when_busy: assert property (
    @(posedge clk) disable iff (rst)
    busy && $past(busy) |-> !rd_resp.valid && !evict.valid
  ) else $error("valid output raised while busy was held");

  a_evict_after_fill: assert property (
    @(posedge clk) disable iff (rst)
    evict.valid |-> $past(fill_req.en && !busy)
  ) else $error("evict.valid without an accepted fill in the cycle before");

endmodule

bind icache_array icache_props icache_props_i (
  .clk      (clk),
  .rst      (rst),
  .rd_req   (rd_req),
  .fill_req (fill_req),
  .busy     (busy),
  .rd_resp  (rd_resp),
  .evict    (evict)
);

// File: src/icache_array.sv
`timescale 1ns/10ps

module icache_array import icache_pkg::*; #(
  parameter int NUM_SETS = 32,
  parameter int NUM_WAYS = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  rd_req_t   rd_req,
  input  fill_req_t fill_req,
  input  logic      inval_all,
  output rd_resp_t  rd_resp,
  output evict_t    evict,
  output logic      busy
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int WAY_W = $clog2(NUM_WAYS);

  logic             sweep_start;
  logic             sweep_clear;
  logic             sweep_last;
  logic [IDX_W-1:0] sweep_idx;

  logic             rd_acc;
  logic             fill_acc;
  rd_req_t          rd_gated;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] fill_idx;

  logic             rd_acc_q;
  logic [IDX_W-1:0] rd_idx_q;
  logic             evict_valid_q;
  line_addr_t       evict_addr_q;

  logic [NUM_WAYS-1:0] rd_hit_w;
  logic [NUM_WAYS-1:0] fill_match_w;
  logic [NUM_WAYS-1:0] fill_valid_w;
  logic [NUM_WAYS-1:0] fill_sel_w;
  line_addr_t          victim_addr_w [NUM_WAYS];
  line_t               rd_line_w [NUM_WAYS];

  logic [WAY_W-1:0] fill_way;
  logic             fill_evict;
  logic             rd_any_hit;

  // AND-OR merge chains, entry 0 seeds with zero
  line_t            data_chain [NUM_WAYS+1];
  logic [WAY_W-1:0] way_chain [NUM_WAYS+1];
  line_addr_t       victim_chain [NUM_WAYS+1];

  icache_ctrl icache_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .inval_all   (inval_all),
    .sweep_last  (sweep_last),
    .sweep_start (sweep_start),
    .sweep_clear (sweep_clear),
    .busy        (busy)
  );

  sweep_counter #(.NUM_SETS(NUM_SETS)) sweep_counter_i (
    .clk         (clk),
    .rst         (rst),
    .sweep_start (sweep_start),
    .sweep_clear (sweep_clear),
    .sweep_idx   (sweep_idx),
    .sweep_last  (sweep_last)
  );

  // nothing is accepted while the sweep runs
  assign rd_acc   = rd_req.en && !busy;
  assign fill_acc = fill_req.en && !busy;
  assign rd_gated = '{en: rd_acc, addr: rd_req.addr};
  assign rd_idx   = rd_req.addr[IDX_W-1:0];
  assign fill_idx = fill_req.addr[IDX_W-1:0];

  assign data_chain[0]   = '0;
  assign way_chain[0]    = '0;
  assign victim_chain[0] = '0;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    assign fill_sel_w[w] = fill_acc && (fill_way == WAY_W'(w));

    tag_way #(.NUM_SETS(NUM_SETS), .WAY(w)) tag_way_i (
      .clk              (clk),
      .rst              (rst),
      .rd_req           (rd_gated),
      .fill_addr        (fill_req.addr),
      .fill_sel         (fill_sel_w[w]),
      .sweep_clear      (sweep_clear),
      .sweep_idx        (sweep_idx),
      .rd_hit           (rd_hit_w[w]),
      .fill_match       (fill_match_w[w]),
      .fill_valid       (fill_valid_w[w]),
      .fill_victim_addr (victim_addr_w[w])
    );

    line_ram #(.NUM_SETS(NUM_SETS)) line_ram_i (
      .clk     (clk),
      .rst     (rst),
      .rd_en   (rd_acc),
      .rd_idx  (rd_idx),
      .wr_en   (fill_sel_w[w]),
      .wr_idx  (fill_idx),
      .wr_line (fill_req.line),
      .rd_line (rd_line_w[w])
    );

    // at most one way hits, so OR-ing the gated values selects it
    assign data_chain[w+1] = data_chain[w] | ({LINE_BITS{rd_hit_w[w]}} & rd_line_w[w]);
    assign way_chain[w+1]  = way_chain[w] | ({WAY_W{rd_hit_w[w]}} & WAY_W'(w));
    assign victim_chain[w+1] =
      victim_chain[w] | ({LINE_ADDR_W{fill_sel_w[w]}} & victim_addr_w[w]);
  end

  assign rd_any_hit = |rd_hit_w;

  nru_state #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) nru_state_i (
    .clk             (clk),
    .rst             (rst),
    .rd_touch        (rd_any_hit),
    .rd_touch_idx    (rd_idx_q),
    .rd_touch_way    (way_chain[NUM_WAYS]),
    .fill_idx        (fill_idx),
    .fill_valid_ways (fill_valid_w),
    .fill_match_ways (fill_match_w),
    .fill_en         (fill_acc),
    .sweep_clear     (sweep_clear),
    .sweep_idx       (sweep_idx),
    .fill_way        (fill_way),
    .fill_evict      (fill_evict)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_acc_q      <= 1'b0;
      evict_valid_q <= 1'b0;
    end else begin
      rd_acc_q      <= rd_acc;
      evict_valid_q <= fill_acc && fill_evict;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rd_idx_q <= rd_idx;
    end
    if (fill_acc) begin
      evict_addr_q <= victim_chain[NUM_WAYS];
    end
  end

  assign rd_resp = '{
    valid: rd_acc_q,
    hit:   rd_any_hit,
    way:   way_idx_t'(way_chain[NUM_WAYS]),
    line:  data_chain[NUM_WAYS]
  };

  assign evict = '{valid: evict_valid_q, line_addr: evict_addr_q};

endmodule

// File: src/nru_state.sv
`timescale 1ns/10ps

module nru_state #(
  parameter int NUM_SETS = 32,
  parameter int NUM_WAYS = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd_touch,
  input  logic [$clog2(NUM_SETS)-1:0] rd_touch_idx,
  input  logic [$clog2(NUM_WAYS)-1:0] rd_touch_way,
  input  logic [$clog2(NUM_SETS)-1:0] fill_idx,
  input  logic [NUM_WAYS-1:0]         fill_valid_ways,
  input  logic [NUM_WAYS-1:0]         fill_match_ways,
  input  logic                        fill_en,
  input  logic                        sweep_clear,
  input  logic [$clog2(NUM_SETS)-1:0] sweep_idx,
  output logic [$clog2(NUM_WAYS)-1:0] fill_way,
  output logic                        fill_evict
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  logic [NUM_WAYS-1:0] used [NUM_SETS];
  logic [NUM_WAYS-1:0] fill_cur;
  logic [NUM_WAYS-1:0] rd_next;
  logic [NUM_WAYS-1:0] fill_base;
  logic [NUM_WAYS-1:0] fill_next;

  // set the touched bit, keep only it once the set would be all ones
  function automatic logic [NUM_WAYS-1:0] mark_used(
    input logic [NUM_WAYS-1:0] bits,
    input logic [WAY_W-1:0]    way
  );
    logic [NUM_WAYS-1:0] hot;
    logic [NUM_WAYS-1:0] nxt;
    hot = NUM_WAYS'(1) << way;
    nxt = bits | hot;
    if (&nxt) begin
      nxt = hot;
    end
    return nxt;
  endfunction

  assign fill_cur = used[fill_idx];

  // victim pick: matching way, then lowest invalid, then lowest unused
  always_comb begin
    logic found;
    found    = 1'b0;
    fill_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && fill_match_ways[w]) begin
        fill_way = WAY_W'(w);
        found    = 1'b1;
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && !fill_valid_ways[w]) begin
        fill_way = WAY_W'(w);
        found    = 1'b1;
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && !fill_cur[w]) begin
        fill_way = WAY_W'(w);
        found    = 1'b1;
      end
    end
  end

  assign fill_evict = fill_valid_ways[fill_way] && !fill_match_ways[fill_way];

  // read touch lands in the response cycle, fill goes on top of it
  assign rd_next   = mark_used(used[rd_touch_idx], rd_touch_way);
  assign fill_base = (rd_touch && (rd_touch_idx == fill_idx)) ? rd_next : fill_cur;
  assign fill_next = mark_used(fill_base, fill_way);

  always_ff @(posedge clk) begin
    if (sweep_clear) begin
      used[sweep_idx] <= '0;
    end else if (!rst) begin
      if (rd_touch) begin
        used[rd_touch_idx] <= rd_next;
      end
      if (fill_en) begin
        used[fill_idx] <= fill_next;
      end
    end
  end

endmodule

// File: src/tag_way.sv
`timescale 1ns/10ps

module tag_way import icache_pkg::*; #(
  parameter int NUM_SETS = 32,
  parameter int WAY      = 0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  rd_req_t                     rd_req,
  input  line_addr_t                  fill_addr,
  input  logic                        fill_sel,
  input  logic                        sweep_clear,
  input  logic [$clog2(NUM_SETS)-1:0] sweep_idx,
  output logic                        rd_hit,
  output logic                        fill_match,
  output logic                        fill_valid,
  output line_addr_t                  fill_victim_addr
);

  localparam int IDX_W = $clog2(NUM_SETS);

  // merge and NRU logic are sized for at most eight ways
  if (WAY < 0 || WAY > 7) begin : g_way_check
    $error("tag_way: WAY out of range");
  end

  // full line address kept as the tag
  line_addr_t       tags [NUM_SETS];
  logic [NUM_SETS-1:0] valid;

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] fill_idx;

  logic       rd_en_q;
  line_addr_t rd_addr_q;
  line_addr_t rd_tag_q;
  logic       rd_valid_q;

  assign rd_idx   = rd_req.addr[IDX_W-1:0];
  assign fill_idx = fill_addr[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_req.en;
    end
  end

  // tag and valid sampled before any fill at this edge lands
  always_ff @(posedge clk) begin
    if (rd_req.en) begin
      rd_addr_q  <= rd_req.addr;
      rd_tag_q   <= tags[rd_idx];
      rd_valid_q <= valid[rd_idx];
    end
  end

  assign rd_hit = rd_en_q && rd_valid_q && (rd_tag_q == rd_addr_q);

  always_ff @(posedge clk) begin
    if (fill_sel) begin
      tags[fill_idx] <= fill_addr;
    end
  end

  // sweep and fill never overlap, requests are held off while sweeping
  always_ff @(posedge clk) begin
    if (sweep_clear) begin
      valid[sweep_idx] <= 1'b0;
    end else if (fill_sel) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  // fill-set lookup, same cycle as the fill
  assign fill_valid       = valid[fill_idx];
  assign fill_victim_addr = tags[fill_idx];
  assign fill_match       = fill_valid && (tags[fill_idx] == fill_addr);

endmodule

// File: src/line_ram.sv
`timescale 1ns/10ps

module line_ram import icache_pkg::*; #(
  parameter int NUM_SETS = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd_en,
  input  logic [$clog2(NUM_SETS)-1:0] rd_idx,
  input  logic                        wr_en,
  input  logic [$clog2(NUM_SETS)-1:0] wr_idx,
  input  line_t                       wr_line,
  output line_t                       rd_line
);

  line_t mem [NUM_SETS];

  // read is registered at the same edge as a write,
  // so a read of the set being filled sees the old line
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_line <= '0;
    end else if (rd_en) begin
      rd_line <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_line;
    end
  end

endmodule

// File: src/sweep_counter.sv
`timescale 1ns/10ps

module sweep_counter #(
  parameter int NUM_SETS = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        sweep_start,
  input  logic                        sweep_clear,
  output logic [$clog2(NUM_SETS)-1:0] sweep_idx,
  output logic                        sweep_last
);

  localparam int IDX_W = $clog2(NUM_SETS);

  // wraps back to zero after the last set, NUM_SETS is a power of two
  always_ff @(posedge clk) begin
    if (rst || sweep_start) begin
      sweep_idx <= '0;
    end else if (sweep_clear) begin
      sweep_idx <= sweep_idx + IDX_W'(1);
    end
  end

  assign sweep_last = (sweep_idx == IDX_W'(NUM_SETS - 1));

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic inval_all,
  input  logic sweep_last,
  output logic sweep_start,
  output logic sweep_clear,
  output logic busy
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_SWEEP: begin
        // last set cleared this cycle
        if (sweep_last) begin
          state_nxt = ST_RUN;
        end
      end
      ST_RUN: begin
        if (inval_all) begin
          state_nxt = ST_SWEEP;
        end
      end
      default: begin
        state_nxt = ST_SWEEP;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_SWEEP;
    end else begin
      state <= state_nxt;
    end
  end

  // restart the index counter on the way back into the sweep
  assign sweep_start = (state == ST_RUN) && inval_all;

  // one set cleared per cycle while sweeping
  assign sweep_clear = (state == ST_SWEEP);

  // requests are dropped, not queued, while this is high
  assign busy = (state == ST_SWEEP);

endmodule

// File: src/icache_pkg.sv
package icache_pkg;

  // line geometry
  localparam int WORD_BITS   = 32;
  localparam int LINE_WORDS  = 4;
  localparam int LINE_BITS   = WORD_BITS * LINE_WORDS;
  localparam int LINE_ADDR_W = 28;
  localparam int WAY_IDX_W   = 2;

  typedef logic [WORD_BITS-1:0]   word_t;
  typedef logic [LINE_BITS-1:0]   line_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;
  typedef logic [WAY_IDX_W-1:0]   way_idx_t;

  typedef struct packed {
    logic       en;
    line_addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic       en;
    line_addr_t addr;
    line_t      line;
  } fill_req_t;

  typedef struct packed {
    logic     valid;
    logic     hit;
    way_idx_t way;
    line_t    line;
  } rd_resp_t;

  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } evict_t;

  typedef enum logic [0:0] {
    ST_SWEEP,
    ST_RUN
  } ctrl_state_t;

endpackage
